// ==== hw/rvPkg.sv ====
`default_nettype none

package rvPkg;

    typedef logic [31:0] wordT;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcodeT;

    typedef enum logic [4:0] {
        fetch, decode,
        execR, execI, aluWb,
        memAddrS, memWrite,
        memAddrL, memRead, loadWb,
        branchEval,
        jalLink, jalrAddr, jalrLink, jumpPc,
        luiWb
    } ctrlStateT;

    typedef enum logic [1:0] {aluAdd, aluBranch, aluRType, aluIType} aluClassT;
    typedef enum logic [2:0] {fnAdd, fnSub, fnAnd, fnOr, fnSlt} aluFuncT;
    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immKindT;

    typedef enum logic [1:0] {srcPc, srcOldPc, srcRegA} srcAT;
    typedef enum logic [1:0] {srcRegB, srcImm, srcFour} srcBT;
    typedef enum logic [1:0] {resAluOut, resDataReg, resAluNow, resImm} resultSrcT;

    typedef struct packed {
        logic      pcUpdate;
        logic      branch;    // branch compare cycle
        logic      irWrite;
        logic      regWrite;
        logic      adrSrc;    // 0 pc, 1 aluOut
        logic      memWrite;
        aluClassT  aluClass;
        srcAT      srcA;
        srcBT      srcB;
        immKindT   immKind;
        resultSrcT resultSrc;
    } ctrlT;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        wordT adr;
        wordT dat;
    } wbReqT;

    typedef struct packed {
        logic ack;
        wordT dat;
    } wbRspT;

endpackage

`default_nettype wire

// ==== hw/mainController.sv ====
`timescale 1ns/10ps
`default_nettype none

module mainController (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire rvPkg::opcodeT opcode,
    input  wire logic        zero,
    input  wire logic        neg,
    input  wire logic [2:0]  funct3,
    input  wire rvPkg::wbRspT bus,
    output rvPkg::ctrlT      ctrl,
    output logic             cyc,
    output logic             stb,
    output logic             we
);
    import rvPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      stbQ;
    logic      ack;
    logic      taken;

    assign ack = bus.ack & stbQ;   // ignore a stray ack while idle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fetch;
            stbQ  <= 1'b0;
        end else begin
            state <= nextState;
            // bus states raise the strobe, every ack drops it for a cycle
            stbQ  <= (nextState inside {fetch, memRead, memWrite}) && !ack;
        end
    end

    always_comb begin
        nextState = fetch;
        case (state)
            fetch:      nextState = ack ? decode : fetch;
            decode: begin
                case (opcode)
                    opReg:    nextState = execR;
                    opImm:    nextState = execI;
                    opStore:  nextState = memAddrS;
                    opLoad:   nextState = memAddrL;
                    opBranch: nextState = branchEval;
                    opJal:    nextState = jalLink;
                    opJalr:   nextState = jalrAddr;
                    opLui:    nextState = luiWb;
                    default:  nextState = fetch;   // unknown opcode, skip it
                endcase
            end
            execR:      nextState = aluWb;
            execI:      nextState = aluWb;
            memAddrS:   nextState = memWrite;
            memWrite:   nextState = ack ? fetch : memWrite;
            memAddrL:   nextState = memRead;
            memRead:    nextState = ack ? loadWb : memRead;
            jalLink:    nextState = jumpPc;
            jalrAddr:   nextState = jalrLink;
            jalrLink:   nextState = jumpPc;
            default:    nextState = fetch;   // aluWb, loadWb, branchEval, jumpPc, luiWb
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;    // beq
            3'b001:  taken = !zero;   // bne
            3'b100:  taken = neg;     // blt
            3'b101:  taken = !neg;    // bge
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            fetch: begin
                ctrl.irWrite   = ack;
                ctrl.pcUpdate  = ack;
                ctrl.srcB      = srcFour;
                ctrl.resultSrc = resAluNow;   // pc + 4, aluOut left alone
            end
            decode: begin
                // branch target, or the jal target when that is what follows
                ctrl.srcA    = srcOldPc;
                ctrl.srcB    = srcImm;
                ctrl.immKind = (opcode == opJal) ? immJ : immB;
            end
            execR: begin
                ctrl.srcA     = srcRegA;
                ctrl.aluClass = aluRType;
            end
            execI: begin
                ctrl.srcA     = srcRegA;
                ctrl.srcB     = srcImm;
                ctrl.aluClass = aluIType;
            end
            aluWb:    ctrl.regWrite = 1'b1;
            memAddrS: begin
                ctrl.srcA    = srcRegA;
                ctrl.srcB    = srcImm;
                ctrl.immKind = immS;
            end
            memWrite: begin
                ctrl.adrSrc    = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.resultSrc = resAluNow;   // keeps the address in aluOut
            end
            memAddrL: begin
                ctrl.srcA = srcRegA;
                ctrl.srcB = srcImm;
            end
            memRead: begin
                ctrl.adrSrc    = 1'b1;
                ctrl.resultSrc = resAluNow;
            end
            loadWb: begin
                ctrl.resultSrc = resDataReg;
                ctrl.regWrite  = 1'b1;
            end
            branchEval: begin
                ctrl.branch   = 1'b1;
                ctrl.srcA     = srcRegA;
                ctrl.aluClass = aluBranch;
            end
            jalLink, jalrLink: begin
                ctrl.srcA      = srcOldPc;
                ctrl.srcB      = srcFour;
                ctrl.resultSrc = resAluNow;
                ctrl.regWrite  = 1'b1;
            end
            jalrAddr: begin
                ctrl.srcA = srcRegA;
                ctrl.srcB = srcImm;
            end
            jumpPc:   ctrl.pcUpdate = 1'b1;
            luiWb: begin
                ctrl.immKind   = immU;
                ctrl.resultSrc = resImm;
                ctrl.regWrite  = 1'b1;
            end
            default: ctrl = '0;
        endcase
        if (ctrl.branch && taken) ctrl.pcUpdate = 1'b1;
    end

    assign cyc = stbQ;
    assign stb = stbQ;
    assign we  = stbQ & ctrl.memWrite;

    // a cycle without ack keeps the request and its direction
    busHeld: assert property (@(posedge clk) disable iff (rst)
        stb && !bus.ack |=> stb && cyc && $stable(we));

    stateLegal: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(state) && state <= luiWb);

    weInStore: assert property (@(posedge clk) disable iff (rst)
        we |-> state == memWrite);

endmodule

`default_nettype wire

// ==== hw/aluDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluDecoder (
    input  wire rvPkg::aluClassT aluClass,
    input  wire logic [2:0]      funct3,
    input  wire logic            funct7b5,
    input  wire logic            opcodeB5,
    output rvPkg::aluFuncT       aluFunc
);
    import rvPkg::*;

    always_comb begin
        case (aluClass)
            aluAdd:    aluFunc = fnAdd;
            aluBranch: aluFunc = fnSub;
            default: begin
                case (funct3)
                    3'b000:  aluFunc = (funct7b5 && opcodeB5) ? fnSub : fnAdd;   // addi stays add
                    3'b010:  aluFunc = fnSlt;
                    3'b110:  aluFunc = fnOr;
                    3'b111:  aluFunc = fnAnd;
                    default: aluFunc = fnAdd;
                endcase
            end
        endcase
        if (!$isunknown(aluClass)) begin
            funcKnown: assert (!$isunknown(aluFunc));
        end
    end

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/10ps
`default_nettype none

module datapath #(
    parameter rvPkg::wordT resetAddr = '0
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire rvPkg::ctrlT    ctrl,
    input  wire rvPkg::aluFuncT aluFunc,
    input  wire rvPkg::wbRspT   bus,
    output rvPkg::wordT         adr,
    output rvPkg::wordT         wdata,
    output rvPkg::opcodeT       opcode,
    output logic [2:0]          funct3,
    output logic                funct7b5,
    output logic                opcodeB5,
    output logic                zero,
    output logic                neg
);
    import rvPkg::*;

    wordT       pcQ;
    wordT       oldPcQ;
    wordT       instrQ;
    wordT       dataQ;
    wordT       aQ;
    wordT       bQ;
    wordT       aluOutQ;
    wordT       regs [0:31];
    wordT       rs1Val;
    wordT       rs2Val;
    wordT       immExt;
    wordT       srcAVal;
    wordT       srcBVal;
    wordT       aluResult;
    wordT       result;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;

    assign opcode   = opcodeT'(instrQ[6:0]);
    assign opcodeB5 = instrQ[5];
    assign funct3   = instrQ[14:12];
    assign funct7b5 = instrQ[30];
    assign rd       = instrQ[11:7];
    assign rs1      = instrQ[19:15];
    assign rs2      = instrQ[24:20];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcQ <= resetAddr;
        end else if (ctrl.pcUpdate) begin
            pcQ <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            instrQ <= bus.dat;
            oldPcQ <= pcQ;   // pc of the instruction being run
        end
        if (bus.ack) begin
            dataQ <= bus.dat;
        end
        aQ <= rs1Val;
        bQ <= rs2Val;
        // live-result cycles leave aluOut holding an earlier address or target
        if (ctrl.resultSrc != resAluNow) begin
            aluOutQ <= aluResult;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && rd != 5'd0) begin
            regs[rd] <= result;
        end
    end

    assign rs1Val = (rs1 == 5'd0) ? '0 : regs[rs1];   // x0 is never written
    assign rs2Val = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_comb begin
        case (ctrl.immKind)
            immI:    immExt = {{20{instrQ[31]}}, instrQ[31:20]};
            immS:    immExt = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};
            immB:    immExt = {{19{instrQ[31]}}, instrQ[31], instrQ[7],
                               instrQ[30:25], instrQ[11:8], 1'b0};
            immU:    immExt = {instrQ[31:12], 12'b0};
            immJ:    immExt = {{11{instrQ[31]}}, instrQ[31], instrQ[19:12],
                               instrQ[20], instrQ[30:21], 1'b0};
            default: immExt = '0;
        endcase
    end

    always_comb begin
        case (ctrl.srcA)
            srcPc:    srcAVal = pcQ;
            srcOldPc: srcAVal = oldPcQ;
            default:  srcAVal = aQ;
        endcase
        case (ctrl.srcB)
            srcImm:  srcBVal = immExt;
            srcFour: srcBVal = 32'd4;
            default: srcBVal = bQ;
        endcase
    end

    always_comb begin
        case (aluFunc)
            fnSub:   aluResult = srcAVal - srcBVal;
            fnAnd:   aluResult = srcAVal & srcBVal;
            fnOr:    aluResult = srcAVal | srcBVal;
            fnSlt:   aluResult = {31'b0, $signed(srcAVal) < $signed(srcBVal)};
            default: aluResult = srcAVal + srcBVal;
        endcase
    end

    assign zero = (aluResult == '0);
    assign neg  = aluResult[31];   // sign of rs1 - rs2 for blt/bge

    always_comb begin
        case (ctrl.resultSrc)
            resDataReg: result = dataQ;
            resAluNow:  result = aluResult;
            resImm:     result = immExt;
            default:    result = aluOutQ;
        endcase
    end

    assign adr   = ctrl.adrSrc ? aluOutQ : pcQ;
    assign wdata = bQ;

    pcAligned: assert property (@(posedge clk) disable iff (rst) pcQ[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/rvMulticycle.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvMulticycle #(
    parameter rvPkg::wordT resetAddr = '0
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire rvPkg::wbRspT wbRsp,
    output rvPkg::wbReqT      wbReq
);
    import rvPkg::*;

    ctrlT       ctrl;
    aluFuncT    aluFunc;
    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       opcodeB5;
    logic       zero;
    logic       neg;
    logic       cyc;
    logic       stb;
    logic       we;
    wordT       adr;
    wordT       wdata;

    // strobes from the FSM, address and write data from the datapath
    assign wbReq = '{cyc: cyc, stb: stb, we: we, adr: adr, dat: wdata};

    mainController controller_i (
        .clk(clk), .rst(rst), .opcode(opcode), .zero(zero), .neg(neg),
        .funct3(funct3), .bus(wbRsp), .ctrl(ctrl), .cyc(cyc), .stb(stb), .we(we)
    );

    aluDecoder aluDecoder_i (
        .aluClass(ctrl.aluClass), .funct3(funct3), .funct7b5(funct7b5),
        .opcodeB5(opcodeB5), .aluFunc(aluFunc)
    );

    datapath #(.resetAddr(resetAddr)) datapath_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .aluFunc(aluFunc), .bus(wbRsp),
        .adr(adr), .wdata(wdata), .opcode(opcode), .funct3(funct3),
        .funct7b5(funct7b5), .opcodeB5(opcodeB5), .zero(zero), .neg(neg)
    );

endmodule

`default_nettype wire

// ==== verification/rvMulticycleTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvMulticycleTb;
    import rvPkg::*;

    logic  clk;
    logic  rst;
    wbRspT wbRsp;
    wbReqT wbReq;

    wordT       mem [0:1023];
    wordT       image [0:1023];   // program and data as loaded from the trace
    logic [1:0] gap;              // idle cycles left before the next ack
    wordT       expAdr [$];
    wordT       expDat [$];
    wordT       finAdr [$];
    wordT       finDat [$];
    wbReqT      seenWrites [$];
    wordT       lastRead;
    logic       halted;

    rvMulticycle #(.resetAddr(32'h0)) dut_i (
        .clk(clk), .rst(rst), .wbRsp(wbRsp), .wbReq(wbReq)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            failNow("word compare failed");
        end
    endtask

    task automatic checkWrite(input string name, input wbReqT act,
                              input wordT adr, input wordT dat);
        if (act.adr !== adr || act.dat !== dat) begin
            $display("ERROR %s: expected adr %h dat %h, actual adr %h dat %h",
                     name, adr, dat, act.adr, act.dat);
            failNow("bus write compare failed");
        end
    endtask

    task automatic readTrace();
        int    fd;
        int    cnt;
        string line;
        logic [7:0] tag;
        wordT  a;
        wordT  d;
        fd = $fopen("verification/programTrace.txt", "r");
        if (fd == 0) failNow("trace file verification/programTrace.txt could not be opened");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%c %h %h", tag, a, d);
            if (cnt == 3) begin
                if (tag == "P") image[a[11:2]] = d;
                else if (tag == "W") begin
                    expAdr.push_back(a);
                    expDat.push_back(d);
                end else if (tag == "E") begin
                    finAdr.push_back(a);
                    finDat.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    // slave with 0 to 3 idle cycles before each ack
    always @(posedge clk) begin
        if (rst) begin
            wbRsp <= '0;
            gap   <= 2'($urandom % 4);
            for (int i = 0; i < 1024; i++) mem[i] <= image[i];
        end else begin
            wbRsp.ack <= 1'b0;
            if (wbReq.cyc && wbReq.stb && !wbRsp.ack) begin
                if (gap == 2'd0) begin
                    wbRsp.ack <= 1'b1;
                    wbRsp.dat <= mem[wbReq.adr[11:2]];
                    if (wbReq.we) mem[wbReq.adr[11:2]] <= wbReq.dat;
                    gap <= 2'($urandom % 4);
                end else begin
                    gap <= gap - 2'd1;
                end
            end
        end
    end

    // cyc follows stb, and we only rides on a strobe
    always @(posedge clk) begin
        if (!rst && wbReq.cyc !== wbReq.stb) begin
            failNow("cyc and stb of the bus request did not rise and fall together");
        end
        if (!rst && wbReq.we && !wbReq.stb) begin
            failNow("we was high while no bus cycle was in progress");
        end
    end

    // completed transfers; the halt loop shows as two reads of one address
    always @(posedge clk) begin
        if (!rst && wbReq.stb && wbRsp.ack) begin
            if (wbReq.we) begin
                seenWrites.push_back(wbReq);
            end else begin
                if (wbReq.adr == lastRead) halted = 1'b1;
                lastRead = wbReq.adr;
            end
        end
    end

    initial begin
        int n;
        void'($urandom(63131));
        for (int i = 0; i < 1024; i++) image[i] = '0;
        rst      = 1'b1;
        wbRsp    = '0;
        halted   = 1'b0;
        lastRead = 32'hFFFF_FFFF;
        readTrace();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (n = 0; n < 20 && !wbReq.stb; n++) @(posedge clk);
        if (!wbReq.stb) failNow("the first instruction fetch never started after reset");
        checkWord("first fetch address", 32'h0, wbReq.adr);
        if (wbReq.we) failNow("the first bus cycle after reset was a write");

        for (int k = 0; k < expAdr.size(); k++) begin
            for (n = 0; n < 2000 && seenWrites.size() == 0; n++) @(posedge clk);
            if (seenWrites.size() == 0) begin
                failNow($sformatf("expected bus write %0d to %h never came", k, expAdr[k]));
            end
            checkWrite($sformatf("bus write %0d", k), seenWrites.pop_front(),
                       expAdr[k], expDat[k]);
        end

        for (n = 0; n < 2000 && !halted; n++) @(posedge clk);
        if (!halted) failNow("the core never reached the self-jump halt loop");
        if (seenWrites.size() != 0) failNow("the core made more bus writes than expected");
        repeat (2) @(posedge clk);
        for (int k = 0; k < finAdr.size(); k++) begin
            checkWord($sformatf("final word %h", finAdr[k]), finDat[k], mem[finAdr[k][11:2]]);
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #2ms;
        failNow("simulation watchdog expired");
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/rvPkg.sv
hw/mainController.sv
hw/aluDecoder.sv
hw/datapath.sv
hw/rvMulticycle.sv
verification/rvMulticycleTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rvMulticycleTb
FLIST     ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASSTEXT  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FLIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== verification/programTrace.txt ====
# tag address data: P program or data word, W expected bus write, E final memory word
# ALU results: x1=5, x2=-3, then add sub and or slt andi ori slti, addi to x0
P 000 00500093
P 004 FFD00113
P 008 002081B3
P 00C 40208233
P 010 0020F2B3
P 014 0020E333
P 018 001123B3
P 01C FFE0F413
P 020 0100E493
P 024 FFF0A513
P 028 00708013
P 02C 20000A13
P 030 003A2023
P 034 004A2223
P 038 005A2423
P 03C 006A2623
P 040 007A2823
P 044 008A2A23
P 048 009A2C23
P 04C 00AA2E23
P 050 020A2023
# lw then sw copies
P 054 100A2583
P 058 02BA2223
P 05C 104A2603
P 060 02CA2423
# branch pairs, a taken branch skips a store to 23C
P 064 00508463
P 068 027A2E23
P 06C 00208463
P 070 021A2623
P 074 00209463
P 078 027A2E23
P 07C 00509463
P 080 022A2823
P 084 00114463
P 088 027A2E23
P 08C 0020C463
P 090 023A2A23
P 094 0020D463
P 098 027A2E23
P 09C 00115463
P 0A0 024A2C23
# jal, jalr, lui, then the halt loop
P 0A4 0080076F
P 0A8 027A2E23
P 0AC 04EA2023
P 0B0 0C000813
P 0B4 000807E7
P 0B8 027A2E23
P 0BC 027A2E23
P 0C0 04FA2223
P 0C4 ABCDEAB7
P 0C8 055A2423
P 0CC 0000006F
P 300 12345678
P 304 CAFEF00D
W 200 00000002
W 204 00000008
W 208 00000005
W 20C FFFFFFFD
W 210 00000001
W 214 00000004
W 218 00000015
W 21C 00000000
W 220 00000000
W 224 12345678
W 228 CAFEF00D
W 22C 00000005
W 230 FFFFFFFD
W 234 00000002
W 238 00000008
W 240 000000A8
W 244 000000B8
W 248 ABCDE000
E 224 12345678
E 228 CAFEF00D
E 23C 00000000
E 248 ABCDE000
